//--- design/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    localparam int word_w = 32;

    // instruction field positions
    localparam int cond_hi       = 31;
    localparam int cond_lo       = 28;
    localparam int class_hi      = 27;
    localparam int class_lo      = 25;
    localparam int opcode_hi     = 27;
    localparam int opcode_lo     = 21;
    localparam int alu_op_hi     = 23;
    localparam int alu_op_lo     = 21;
    localparam int rn_hi         = 19;
    localparam int rn_lo         = 16;
    localparam int rd_hi         = 15;
    localparam int rd_lo         = 12;
    localparam int rs_hi         = 11;
    localparam int rs_lo         = 8;
    localparam int imm5_hi       = 11;
    localparam int imm5_lo       = 7;
    localparam int shift_op_hi   = 6;
    localparam int shift_op_lo   = 5;
    localparam int reg_shift_bit = 4;
    localparam int rm_hi         = 3;
    localparam int rm_lo         = 0;
    localparam int imm12_hi      = 11;
    localparam int imm12_lo      = 0;
    localparam int imm24_hi      = 23;
    localparam int imm24_lo      = 0;

    // p_bit doubles as the link bit for branches
    localparam int p_bit = 24;
    localparam int u_bit = 23;
    localparam int w_bit = 21;
    localparam int l_bit = 20;
    localparam int s_bit = 20;

    // NZCV in the status word
    localparam int flag_n = 31;
    localparam int flag_z = 30;
    localparam int flag_c = 29;
    localparam int flag_v = 28;

    localparam logic [2:0] cls_dp_reg = 3'b000;
    localparam logic [2:0] cls_dp_imm = 3'b001;
    localparam logic [2:0] cls_ldst   = 3'b010;
    localparam logic [2:0] cls_branch = 3'b101;

    localparam logic [3:0] cc_eq = 4'b0000;
    localparam logic [3:0] cc_ne = 4'b0001;
    localparam logic [3:0] cc_cs = 4'b0010;
    localparam logic [3:0] cc_cc = 4'b0011;
    localparam logic [3:0] cc_mi = 4'b0100;
    localparam logic [3:0] cc_pl = 4'b0101;
    localparam logic [3:0] cc_vs = 4'b0110;
    localparam logic [3:0] cc_vc = 4'b0111;
    localparam logic [3:0] cc_hi = 4'b1000;
    localparam logic [3:0] cc_ls = 4'b1001;
    localparam logic [3:0] cc_ge = 4'b1010;
    localparam logic [3:0] cc_lt = 4'b1011;
    localparam logic [3:0] cc_gt = 4'b1100;
    localparam logic [3:0] cc_le = 4'b1101;
    localparam logic [3:0] cc_al = 4'b1110;
    localparam logic [3:0] cc_nv = 4'b1111;

    localparam logic [2:0] alu_add = 3'b000;
    localparam logic [2:0] alu_sub = 3'b001;

    localparam logic [1:0] pc_next   = 2'b00;
    localparam logic [1:0] pc_reset  = 2'b01;
    localparam logic [1:0] pc_branch = 2'b10;

    localparam logic [1:0] src_none = 2'b00;
    localparam logic [1:0] src_reg  = 2'b01;
    localparam logic [1:0] src_imm  = 2'b10;

    typedef enum logic [2:0] {
        st_load_pc,
        st_fetch,
        st_fetch_wait,
        st_execute,
        st_memory,
        st_memory_wait,
        st_write_back,
        st_run
    } startup_state_t;

    // what a load needs for its late register write
    typedef struct packed {
        logic       is_load;
        logic [3:0] rd;
    } ldr_slot_t;

endpackage

`default_nettype wire

//--- design/pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     squash,
    input  payload_t d,
    input  logic     d_valid,
    output payload_t q,
    output logic     q_valid
);

    // squash turns the incoming entry into a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (en) begin
            q_valid <= d_valid & ~squash;
        end
    end

    // old contents stay put unless a valid entry lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (en && d_valid && !squash) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- design/startup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module startup_sequencer (
    input  logic clk,
    input  logic rst_n,
    output logic en_ex,
    output logic en_mem,
    output logic en_wait,
    output logic en_wb,
    output logic start_load_pc,
    output logic running
);

    cpu_ctrl_pkg::startup_state_t state;

    // one state per clock, then park in run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_ctrl_pkg::st_load_pc;
        end else begin
            case (state)
                cpu_ctrl_pkg::st_load_pc:     state <= cpu_ctrl_pkg::st_fetch;
                cpu_ctrl_pkg::st_fetch:       state <= cpu_ctrl_pkg::st_fetch_wait;
                cpu_ctrl_pkg::st_fetch_wait:  state <= cpu_ctrl_pkg::st_execute;
                cpu_ctrl_pkg::st_execute:     state <= cpu_ctrl_pkg::st_memory;
                cpu_ctrl_pkg::st_memory:      state <= cpu_ctrl_pkg::st_memory_wait;
                cpu_ctrl_pkg::st_memory_wait: state <= cpu_ctrl_pkg::st_write_back;
                default:                      state <= cpu_ctrl_pkg::st_run;
            endcase
        end
    end

    // stages switch on in order and never off again
    assign en_ex   = (state >= cpu_ctrl_pkg::st_execute);
    assign en_mem  = (state >= cpu_ctrl_pkg::st_memory);
    assign en_wait = (state >= cpu_ctrl_pkg::st_memory_wait);
    assign en_wb   = (state >= cpu_ctrl_pkg::st_write_back);

    // reset vector load is also requested while rst_n is low
    assign start_load_pc = (state == cpu_ctrl_pkg::st_load_pc);
    assign running       = (state == cpu_ctrl_pkg::st_run);

endmodule

`default_nettype wire

//--- design/execute_decode.sv
`timescale 1ns/1ps
`default_nettype none

module execute_decode (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            squash,
    input  logic [cpu_ctrl_pkg::word_w-1:0] instr_in,
    output logic [cpu_ctrl_pkg::word_w-1:0] instr_ex,
    output logic                            valid_ex,
    output logic [6:0]                      opcode_ex,
    output logic [3:0]                      rn_ex,
    output logic [3:0]                      rs_ex,
    output logic [3:0]                      rm_ex,
    output logic [4:0]                      imm5_ex,
    output logic [1:0]                      sel_a_in,
    output logic [1:0]                      sel_b_in,
    output logic [1:0]                      sel_shift_in,
    output logic                            sel_shift,
    output logic                            en_a,
    output logic                            en_b,
    output logic                            en_s
);

    logic [2:0] cls_ex;

    // instr_in is always a real fetch once the stage runs
    pipe_stage #(
        .payload_t(logic [cpu_ctrl_pkg::word_w-1:0])
    ) u_ex_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .squash (squash),
        .d      (instr_in),
        .d_valid(1'b1),
        .q      (instr_ex),
        .q_valid(valid_ex)
    );

    assign cls_ex    = instr_ex[cpu_ctrl_pkg::class_hi:cpu_ctrl_pkg::class_lo];
    assign opcode_ex = instr_ex[cpu_ctrl_pkg::opcode_hi:cpu_ctrl_pkg::opcode_lo];
    assign rn_ex     = instr_ex[cpu_ctrl_pkg::rn_hi:cpu_ctrl_pkg::rn_lo];
    assign rs_ex     = instr_ex[cpu_ctrl_pkg::rs_hi:cpu_ctrl_pkg::rs_lo];
    assign rm_ex     = instr_ex[cpu_ctrl_pkg::rm_hi:cpu_ctrl_pkg::rm_lo];
    assign imm5_ex   = instr_ex[cpu_ctrl_pkg::imm5_hi:cpu_ctrl_pkg::imm5_lo];

    // operand fetch controls for the register read ports
    always_comb begin
        sel_a_in     = cpu_ctrl_pkg::src_none;
        sel_b_in     = cpu_ctrl_pkg::src_none;
        sel_shift_in = cpu_ctrl_pkg::src_none;
        sel_shift    = 1'b0;
        en_a         = 1'b0;
        en_b         = 1'b0;
        en_s         = 1'b0;
        if (valid_ex) begin
            case (cls_ex)
                cpu_ctrl_pkg::cls_dp_reg: begin
                    sel_a_in     = cpu_ctrl_pkg::src_reg;
                    sel_b_in     = cpu_ctrl_pkg::src_reg;
                    en_a         = 1'b1;
                    en_b         = 1'b1;
                    en_s         = 1'b1;
                    // shift amount from rs or from imm5
                    sel_shift    = instr_ex[cpu_ctrl_pkg::reg_shift_bit];
                    sel_shift_in = instr_ex[cpu_ctrl_pkg::reg_shift_bit] ?
                                   cpu_ctrl_pkg::src_reg : cpu_ctrl_pkg::src_imm;
                end
                cpu_ctrl_pkg::cls_dp_imm: begin
                    sel_a_in = cpu_ctrl_pkg::src_reg;
                    en_a     = 1'b1;
                end
                cpu_ctrl_pkg::cls_ldst: begin
                    // base register and store data
                    sel_a_in = cpu_ctrl_pkg::src_reg;
                    sel_b_in = cpu_ctrl_pkg::src_reg;
                    en_a     = 1'b1;
                    en_b     = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/memory_control.sv
`timescale 1ns/1ps
`default_nettype none

module memory_control (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic [cpu_ctrl_pkg::word_w-1:0] instr_ex,
    input  logic                            valid_ex,
    input  logic [cpu_ctrl_pkg::word_w-1:0] status_reg,
    input  logic                            start_load_pc,
    input  logic                            running,
    output logic [3:0]                      cond_mem,
    output logic [6:0]                      opcode_mem,
    output logic [3:0]                      rd_mem,
    output logic [1:0]                      shift_op_mem,
    output logic [11:0]                     imm12_mem,
    output logic [23:0]                     imm24_mem,
    output logic [1:0]                      sel_pc,
    output logic                            load_pc,
    output logic                            sel_branch_imm,
    output logic                            sel_a,
    output logic                            sel_b,
    output logic [2:0]                      alu_op,
    output logic                            sel_post_indexing,
    output logic                            en_status,
    output logic                            sel_load_lr,
    output logic                            w_en1,
    output logic                            mem_w_en,
    output logic                            branch_taken,
    output cpu_ctrl_pkg::ldr_slot_t         slot,
    output logic                            slot_valid
);

    logic [cpu_ctrl_pkg::word_w-1:0] instr_mem;
    logic                            valid_mem;
    logic [2:0]                      cls_mem;
    logic                            n_f;
    logic                            z_f;
    logic                            c_f;
    logic                            v_f;
    logic                            cond_pass;
    logic                            exec_mem;

    pipe_stage #(
        .payload_t(logic [cpu_ctrl_pkg::word_w-1:0])
    ) u_mem_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .squash (branch_taken),
        .d      (instr_ex),
        .d_valid(valid_ex),
        .q      (instr_mem),
        .q_valid(valid_mem)
    );

    assign cls_mem      = instr_mem[cpu_ctrl_pkg::class_hi:cpu_ctrl_pkg::class_lo];
    assign cond_mem     = instr_mem[cpu_ctrl_pkg::cond_hi:cpu_ctrl_pkg::cond_lo];
    assign opcode_mem   = instr_mem[cpu_ctrl_pkg::opcode_hi:cpu_ctrl_pkg::opcode_lo];
    assign rd_mem       = instr_mem[cpu_ctrl_pkg::rd_hi:cpu_ctrl_pkg::rd_lo];
    assign shift_op_mem = instr_mem[cpu_ctrl_pkg::shift_op_hi:cpu_ctrl_pkg::shift_op_lo];
    assign imm12_mem    = instr_mem[cpu_ctrl_pkg::imm12_hi:cpu_ctrl_pkg::imm12_lo];
    assign imm24_mem    = instr_mem[cpu_ctrl_pkg::imm24_hi:cpu_ctrl_pkg::imm24_lo];

    assign n_f = status_reg[cpu_ctrl_pkg::flag_n];
    assign z_f = status_reg[cpu_ctrl_pkg::flag_z];
    assign c_f = status_reg[cpu_ctrl_pkg::flag_c];
    assign v_f = status_reg[cpu_ctrl_pkg::flag_v];

    // ARM condition table
    always_comb begin
        case (cond_mem)
            cpu_ctrl_pkg::cc_eq: cond_pass = z_f;
            cpu_ctrl_pkg::cc_ne: cond_pass = ~z_f;
            cpu_ctrl_pkg::cc_cs: cond_pass = c_f;
            cpu_ctrl_pkg::cc_cc: cond_pass = ~c_f;
            cpu_ctrl_pkg::cc_mi: cond_pass = n_f;
            cpu_ctrl_pkg::cc_pl: cond_pass = ~n_f;
            cpu_ctrl_pkg::cc_vs: cond_pass = v_f;
            cpu_ctrl_pkg::cc_vc: cond_pass = ~v_f;
            cpu_ctrl_pkg::cc_hi: cond_pass = c_f & ~z_f;
            cpu_ctrl_pkg::cc_ls: cond_pass = ~c_f | z_f;
            cpu_ctrl_pkg::cc_ge: cond_pass = (n_f == v_f);
            cpu_ctrl_pkg::cc_lt: cond_pass = (n_f != v_f);
            cpu_ctrl_pkg::cc_gt: cond_pass = ~z_f & (n_f == v_f);
            cpu_ctrl_pkg::cc_le: cond_pass = z_f | (n_f != v_f);
            cpu_ctrl_pkg::cc_al: cond_pass = 1'b1;
            cpu_ctrl_pkg::cc_nv: cond_pass = 1'b0;
            default:             cond_pass = 1'b0;
        endcase
    end

    assign exec_mem = valid_mem & cond_pass;

    // operand A is always the register path here
    assign sel_a = 1'b0;

    always_comb begin
        sel_branch_imm    = 1'b0;
        sel_b             = 1'b0;
        alu_op            = cpu_ctrl_pkg::alu_add;
        sel_post_indexing = 1'b0;
        en_status         = 1'b0;
        sel_load_lr       = 1'b0;
        w_en1             = 1'b0;
        mem_w_en          = 1'b0;
        branch_taken      = 1'b0;
        if (exec_mem) begin
            case (cls_mem)
                cpu_ctrl_pkg::cls_dp_reg, cpu_ctrl_pkg::cls_dp_imm: begin
                    alu_op    = instr_mem[cpu_ctrl_pkg::alu_op_hi:cpu_ctrl_pkg::alu_op_lo];
                    sel_b     = (cls_mem == cpu_ctrl_pkg::cls_dp_imm);
                    en_status = instr_mem[cpu_ctrl_pkg::s_bit];
                    w_en1     = 1'b1;
                end
                cpu_ctrl_pkg::cls_ldst: begin
                    alu_op = instr_mem[cpu_ctrl_pkg::u_bit] ?
                             cpu_ctrl_pkg::alu_add : cpu_ctrl_pkg::alu_sub;
                    sel_b             = 1'b1;
                    sel_post_indexing = ~instr_mem[cpu_ctrl_pkg::p_bit];
                    // base write-back for pre-index with W, always for post-index
                    w_en1    = instr_mem[cpu_ctrl_pkg::w_bit] | ~instr_mem[cpu_ctrl_pkg::p_bit];
                    mem_w_en = ~instr_mem[cpu_ctrl_pkg::l_bit];
                end
                cpu_ctrl_pkg::cls_branch: begin
                    branch_taken   = 1'b1;
                    sel_branch_imm = 1'b1;
                    sel_load_lr    = instr_mem[cpu_ctrl_pkg::p_bit];
                    w_en1          = instr_mem[cpu_ctrl_pkg::p_bit];
                end
                default: begin
                end
            endcase
        end
    end

    // pc loads every cycle once running
    assign load_pc = start_load_pc | running;
    assign sel_pc  = start_load_pc ? cpu_ctrl_pkg::pc_reset :
                     branch_taken  ? cpu_ctrl_pkg::pc_branch : cpu_ctrl_pkg::pc_next;

    // only executed loads head for the late write port
    assign slot.is_load = (cls_mem == cpu_ctrl_pkg::cls_ldst) & instr_mem[cpu_ctrl_pkg::l_bit];
    assign slot.rd      = rd_mem;
    assign slot_valid   = exec_mem & slot.is_load;

endmodule

`default_nettype wire

//--- design/writeback_control.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en_wait,
    input  logic                    en_wb,
    input  cpu_ctrl_pkg::ldr_slot_t slot,
    input  logic                    slot_valid,
    output logic                    w_en_ldr,
    output logic [3:0]              rd_ldr
);

    cpu_ctrl_pkg::ldr_slot_t wait_slot;
    logic                    wait_valid;
    cpu_ctrl_pkg::ldr_slot_t wb_slot;
    logic                    wb_valid;

    // data memory read latency
    pipe_stage #(
        .payload_t(cpu_ctrl_pkg::ldr_slot_t)
    ) u_wait_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en_wait),
        .squash (1'b0),
        .d      (slot),
        .d_valid(slot_valid),
        .q      (wait_slot),
        .q_valid(wait_valid)
    );

    pipe_stage #(
        .payload_t(cpu_ctrl_pkg::ldr_slot_t)
    ) u_wb_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en_wb),
        .squash (1'b0),
        .d      (wait_slot),
        .d_valid(wait_valid),
        .q      (wb_slot),
        .q_valid(wb_valid)
    );

    assign w_en_ldr = wb_valid & wb_slot.is_load;
    assign rd_ldr   = wb_slot.rd;

endmodule

`default_nettype wire

//--- design/pipeline_controller.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_controller (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cpu_ctrl_pkg::word_w-1:0] instr_in,
    input  logic [cpu_ctrl_pkg::word_w-1:0] status_reg,
    // execute stage
    output logic [6:0]                      opcode_ex,
    output logic [3:0]                      rn_ex,
    output logic [3:0]                      rs_ex,
    output logic [3:0]                      rm_ex,
    output logic [4:0]                      imm5_ex,
    output logic [1:0]                      sel_a_in,
    output logic [1:0]                      sel_b_in,
    output logic [1:0]                      sel_shift_in,
    output logic                            sel_shift,
    output logic                            en_a,
    output logic                            en_b,
    output logic                            en_s,
    // memory stage
    output logic [3:0]                      cond_mem,
    output logic [6:0]                      opcode_mem,
    output logic [3:0]                      rd_mem,
    output logic [1:0]                      shift_op_mem,
    output logic [11:0]                     imm12_mem,
    output logic [23:0]                     imm24_mem,
    output logic [1:0]                      sel_pc,
    output logic                            load_pc,
    output logic                            sel_branch_imm,
    output logic                            sel_a,
    output logic                            sel_b,
    output logic [2:0]                      alu_op,
    output logic                            sel_post_indexing,
    output logic                            en_status,
    output logic                            sel_load_lr,
    output logic                            w_en1,
    output logic                            mem_w_en,
    // load write-back
    output logic                            w_en_ldr,
    output logic [3:0]                      rd_ldr
);

    logic                            en_ex;
    logic                            en_mem;
    logic                            en_wait;
    logic                            en_wb;
    logic                            start_load_pc;
    logic                            running;
    logic [cpu_ctrl_pkg::word_w-1:0] instr_ex;
    logic                            valid_ex;
    logic                            branch_taken;
    cpu_ctrl_pkg::ldr_slot_t         slot;
    logic                            slot_valid;

    // same-named nets connect implicitly
    startup_sequencer u_startup_sequencer (.*);

    execute_decode u_execute_decode (
        .en    (en_ex),
        .squash(branch_taken),
        .*
    );

    memory_control u_memory_control (
        .en(en_mem),
        .*
    );

    writeback_control u_writeback_control (.*);

endmodule

`default_nettype wire

//--- sim/tb_pipeline_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_controller;

    localparam int n_start   = 12;
    localparam int n_exec    = 40;
    localparam int n_cond    = 64;
    localparam int n_ldst    = 24;
    localparam int n_branch  = 20;
    localparam int n_settle  = 4;
    // reset, explicit sequences and the settle gaps after each test
    localparam int stim_cycles = 8 + 1 + n_start + n_exec + n_cond + n_ldst + 6 + 9 +
                                 n_branch + 5 * n_settle;
    localparam int watchdog_ns = stim_cycles * 4 + 200;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_in;
    logic [31:0] status_reg;
    logic [6:0]  opcode_ex;
    logic [3:0]  rn_ex;
    logic [3:0]  rs_ex;
    logic [3:0]  rm_ex;
    logic [4:0]  imm5_ex;
    logic [1:0]  sel_a_in;
    logic [1:0]  sel_b_in;
    logic [1:0]  sel_shift_in;
    logic        sel_shift;
    logic        en_a;
    logic        en_b;
    logic        en_s;
    logic [3:0]  cond_mem;
    logic [6:0]  opcode_mem;
    logic [3:0]  rd_mem;
    logic [1:0]  shift_op_mem;
    logic [11:0] imm12_mem;
    logic [23:0] imm24_mem;
    logic [1:0]  sel_pc;
    logic        load_pc;
    logic        sel_branch_imm;
    logic        sel_a;
    logic        sel_b;
    logic [2:0]  alu_op;
    logic        sel_post_indexing;
    logic        en_status;
    logic        sel_load_lr;
    logic        w_en1;
    logic        mem_w_en;
    logic        w_en_ldr;
    logic [3:0]  rd_ldr;

    integer      seed;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    // reference pipeline
    int          m_state;
    logic [31:0] m_ex_word;
    logic        m_ex_valid;
    logic [31:0] m_mem_word;
    logic        m_mem_valid;
    logic        m_wait_valid;
    logic [3:0]  m_wait_rd;
    logic        m_wb_valid;
    logic [3:0]  m_wb_rd;

    pipeline_controller u_pipeline_controller (.*);

    always #2 clk = ~clk;

    // bit 0 of an ARM condition inverts its pair
    function automatic logic cond_holds(input logic [3:0] cond, input logic [31:0] flags);
        logic n;
        logic z;
        logic c;
        logic v;
        logic base;
        n = flags[31];
        z = flags[30];
        c = flags[29];
        v = flags[28];
        case (cond[3:1])
            3'd0:    base = z;
            3'd1:    base = c;
            3'd2:    base = n;
            3'd3:    base = v;
            3'd4:    base = c && !z;
            3'd5:    base = (n == v);
            3'd6:    base = !z && (n == v);
            default: base = 1'b1;
        endcase
        return base ^ cond[0];
    endfunction

    function automatic logic model_exec();
        return m_mem_valid && cond_holds(m_mem_word[31:28], status_reg);
    endfunction

    function automatic logic model_taken();
        return model_exec() && (m_mem_word[27:25] == cpu_ctrl_pkg::cls_branch);
    endfunction

    function automatic logic model_load();
        return model_exec() && (m_mem_word[27:25] == cpu_ctrl_pkg::cls_ldst) && m_mem_word[20];
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_state      <= 0;
            m_ex_word    <= '0;
            m_ex_valid   <= 1'b0;
            m_mem_word   <= '0;
            m_mem_valid  <= 1'b0;
            m_wait_valid <= 1'b0;
            m_wait_rd    <= '0;
            m_wb_valid   <= 1'b0;
            m_wb_rd      <= '0;
        end else begin
            if (m_state < 7) begin
                m_state <= m_state + 1;
            end
            // execute from st_execute on
            if (m_state >= 3) begin
                m_ex_valid <= !model_taken();
                if (!model_taken()) begin
                    m_ex_word <= instr_in;
                end
            end
            if (m_state >= 4) begin
                m_mem_valid <= m_ex_valid && !model_taken();
                if (m_ex_valid && !model_taken()) begin
                    m_mem_word <= m_ex_word;
                end
            end
            if (m_state >= 5) begin
                m_wait_valid <= model_load();
                if (model_load()) begin
                    m_wait_rd <= m_mem_word[15:12];
                end
            end
            if (m_state >= 6) begin
                m_wb_valid <= m_wait_valid;
                if (m_wait_valid) begin
                    m_wb_rd <= m_wait_rd;
                end
            end
        end
    end

    task automatic check_value(input string sig, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", test_name, sig, expected, actual);
            test_errs++;
        end
    endtask

    task automatic compare_outputs();
        logic [2:0] cls_e;
        logic [2:0] cls_m;
        logic [9:0] ex_ctl;
        logic       b_imm;
        logic [2:0] op;
        logic       post;
        logic       set_flags;
        logic       link;
        logic       wr_base;
        logic       store;
        logic [1:0] pc_sel;
        cls_e  = m_ex_word[27:25];
        cls_m  = m_mem_word[27:25];
        ex_ctl = '0;
        if (m_ex_valid) begin
            case (cls_e)
                cpu_ctrl_pkg::cls_dp_reg: ex_ctl = {cpu_ctrl_pkg::src_reg, cpu_ctrl_pkg::src_reg,
                    m_ex_word[4] ? cpu_ctrl_pkg::src_reg : cpu_ctrl_pkg::src_imm,
                    m_ex_word[4], 3'b111};
                cpu_ctrl_pkg::cls_dp_imm: ex_ctl = {cpu_ctrl_pkg::src_reg, 8'b0000_0100};
                cpu_ctrl_pkg::cls_ldst:   ex_ctl = {cpu_ctrl_pkg::src_reg, cpu_ctrl_pkg::src_reg,
                    6'b00_0110};
                default:                  ex_ctl = '0;
            endcase
        end
        check_value("ex_fields", {m_ex_word[27:21], m_ex_word[19:16], m_ex_word[11:8],
                    m_ex_word[3:0], m_ex_word[11:7]}, {opcode_ex, rn_ex, rs_ex, rm_ex, imm5_ex});
        check_value("ex_controls", ex_ctl,
                    {sel_a_in, sel_b_in, sel_shift_in, sel_shift, en_a, en_b, en_s});

        b_imm     = 1'b0;
        op        = cpu_ctrl_pkg::alu_add;
        post      = 1'b0;
        set_flags = 1'b0;
        link      = 1'b0;
        wr_base   = 1'b0;
        store     = 1'b0;
        if (model_exec()) begin
            case (cls_m)
                cpu_ctrl_pkg::cls_dp_reg, cpu_ctrl_pkg::cls_dp_imm: begin
                    op        = m_mem_word[23:21];
                    b_imm     = (cls_m == cpu_ctrl_pkg::cls_dp_imm);
                    set_flags = m_mem_word[20];
                    wr_base   = 1'b1;
                end
                cpu_ctrl_pkg::cls_ldst: begin
                    op      = m_mem_word[23] ? cpu_ctrl_pkg::alu_add : cpu_ctrl_pkg::alu_sub;
                    b_imm   = 1'b1;
                    post    = !m_mem_word[24];
                    wr_base = m_mem_word[21] || !m_mem_word[24];
                    store   = !m_mem_word[20];
                end
                cpu_ctrl_pkg::cls_branch: begin
                    link    = m_mem_word[24];
                    wr_base = m_mem_word[24];
                end
                default: begin
                end
            endcase
        end
        check_value("mem_fields", {m_mem_word[31:28], m_mem_word[27:21], m_mem_word[15:12],
                    m_mem_word[6:5], m_mem_word[11:0], m_mem_word[23:0]},
                    {cond_mem, opcode_mem, rd_mem, shift_op_mem, imm12_mem, imm24_mem});
        check_value("mem_controls", {model_taken(), 1'b0, b_imm, op, post, set_flags, link,
                    wr_base, store}, {sel_branch_imm, sel_a, sel_b, alu_op, sel_post_indexing,
                    en_status, sel_load_lr, w_en1, mem_w_en});

        pc_sel = (m_state == 0) ? cpu_ctrl_pkg::pc_reset :
                 model_taken()  ? cpu_ctrl_pkg::pc_branch : cpu_ctrl_pkg::pc_next;
        check_value("pc_controls", {(m_state == 0 || m_state == 7), pc_sel}, {load_pc, sel_pc});
        check_value("load_writeback", {m_wb_valid, m_wb_rd}, {w_en_ldr, rd_ldr});
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        if (rst_n) begin
            compare_outputs();
        end
    end

    task automatic drive_word(input logic [31:0] word);
        @(posedge clk);
        instr_in   <= word;
        status_reg <= $random(seed);
    endtask

    task automatic drive_class(input logic [3:0] cond, input logic [2:0] cls);
        logic [31:0] body;
        body = $random(seed);
        drive_word({cond, cls, body[24:0]});
    endtask

    // no-op class bubbles let the previous test drain
    task automatic settle();
        repeat (n_settle) drive_word({cpu_ctrl_pkg::cc_al, 3'b111, 25'h0});
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        settle();
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %-14s %s (%0d errors)", test_name, test_errs == 0 ? "ok" : "failed",
                 test_errs);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests completed");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_in     = '0;
        status_reg   = '0;
        seed         = 32'h765d_fcac;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_test("start_up");
        repeat (8) drive_word($random(seed));
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("first_pc", {1'b1, cpu_ctrl_pkg::pc_reset}, {load_pc, sel_pc});
        repeat (n_start) drive_word($random(seed));
        end_test();

        start_test("execute_decode");
        for (int i = 0; i < n_exec; i++) begin
            drive_class($random(seed), i[2:0]);
        end
        end_test();

        start_test("conditions");
        for (int i = 0; i < n_cond; i++) begin
            drive_class(i[5:2], i[0] ? cpu_ctrl_pkg::cls_dp_imm : cpu_ctrl_pkg::cls_dp_reg);
        end
        end_test();

        start_test("load_store");
        for (int i = 0; i < n_ldst; i++) begin
            drive_class($random(seed), cpu_ctrl_pkg::cls_ldst);
        end
        // executed load, failed load, post-index store
        drive_word({cpu_ctrl_pkg::cc_al, cpu_ctrl_pkg::cls_ldst, 5'b11001, 4'h3, 4'ha, 12'h010});
        drive_word({cpu_ctrl_pkg::cc_nv, cpu_ctrl_pkg::cls_ldst, 5'b11001, 4'h3, 4'h5, 12'h010});
        drive_word({cpu_ctrl_pkg::cc_al, cpu_ctrl_pkg::cls_ldst, 5'b00000, 4'h2, 4'h7, 12'h004});
        repeat (3) drive_word({cpu_ctrl_pkg::cc_al, 3'b111, 25'h0});
        end_test();

        start_test("branch_squash");
        // taken with link, taken plain and never taken branches each chased by two ALU ops
        for (int i = 0; i < 3; i++) begin
            drive_word({i == 2 ? cpu_ctrl_pkg::cc_nv : cpu_ctrl_pkg::cc_al,
                        cpu_ctrl_pkg::cls_branch, i == 0, 24'h000010});
            drive_class(cpu_ctrl_pkg::cc_al, cpu_ctrl_pkg::cls_dp_reg);
            drive_class(cpu_ctrl_pkg::cc_al, cpu_ctrl_pkg::cls_dp_imm);
        end
        for (int i = 0; i < n_branch; i++) begin
            drive_class($random(seed), i[0] ? cpu_ctrl_pkg::cls_branch : cpu_ctrl_pkg::cls_ldst);
        end
        end_test();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/cpu_ctrl_pkg.sv
design/pipe_stage.sv
design/startup_sequencer.sv
design/execute_decode.sv
design/memory_control.sv
design/writeback_control.sv
design/pipeline_controller.sv
sim/tb_pipeline_controller.sv
